/* include/demod_defs.svh */
`ifndef DEMOD_DEFS_SVH
`define DEMOD_DEFS_SVH

// ********************
// register space
// ********************

`define VERSION_NUMBER     16'h005d

// misc space is 16 words starting at word address 3f0
`define MISC_SPACE_BASE    11'h3f0
`define MISC_SPACE_MASK    11'h7f0

// offsets come from word address bits 3:2, bit 1 picks the upper half
`define MISC_RESET_OFS     2'd0
`define MISC_VERSION_OFS   2'd1
`define MISC_CLOCK_OFS     2'd2

// ********************
// reset and sample path
// ********************

`define SOFT_RESET_CYCLES  6   // dac reset pulse length in clocks
`define IF_PAD_BITS        4   // adc word to 18-bit demod sample

`endif

/* logic/demod_pkg.sv */
`default_nettype none

package demod_pkg;

  // processor side
  typedef logic [10:0] bus_addr_t;   // word address, pins addr1..addr11
  typedef logic [15:0] bus_data_t;

  // internal registers are 32 bits, read back as two 16-bit halves
  typedef logic [31:0] reg_word_t;

  // ********************
  // sample path
  // ********************

  // raw adc word, two's complement
  typedef logic [13:0] adc_sample_t;

  // adc word padded up to the demodulator sample width
  typedef logic [17:0] if_sample_t;

  // offset binary code for the dac pins
  typedef logic [13:0] dac_code_t;

endpackage

`default_nettype wire

/* logic/cpu_bus_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "demod_defs.svh"

module cpu_bus_decode (
  input  wire                        ck933,
  input  wire                        clockCounterEn,
  input  wire                        cs_n_i,
  input  wire                        rd_n_i,
  input  wire                        we_n_i,
  input  wire demod_pkg::bus_addr_t  addr_i,
  input  wire demod_pkg::reg_word_t  misc_dout_i,
  output logic                       misc_sel_o,
  output logic                       wr_o,
  output logic                       rd_o,
  output demod_pkg::bus_data_t       data_o,
  output logic                       data_oe_o
);

  logic bus_rd;   // cs and rd both low
  logic rd_q;     // bus_rd as seen at the last edge

  // ********************
  // address and strobes
  // ********************

  assign misc_sel_o = ~cs_n_i &
                      ((addr_i & `MISC_SPACE_MASK) == `MISC_SPACE_BASE);

  assign wr_o   = ~cs_n_i & ~we_n_i;   // every sampled cycle is a write
  assign bus_rd = ~cs_n_i & ~rd_n_i;

  // side effects of a read fire once, even when rd is held for several clocks
  assign rd_o = bus_rd & ~rd_q;

  always_ff @(posedge ck933 or posedge clockCounterEn) begin
    if (clockCounterEn) begin
      rd_q <= 1'b0;
    end else begin
      rd_q <= bus_rd;
    end
  end

  // ********************
  // read data mux
  // ********************

  always_comb begin
    data_o = '0;   // nothing else mapped
    if (misc_sel_o) begin
      if (addr_i[1]) begin
        data_o = misc_dout_i[31:16];
      end else begin
        data_o = misc_dout_i[15:0];
      end
    end
  end

  assign data_oe_o = bus_rd;   // follows the pins, no clock involved

endmodule

`default_nettype wire

/* logic/misc_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "demod_defs.svh"

module misc_regs (
  input  wire                        ck933,
  input  wire                        clockCounterEn,
  input  wire                        misc_sel_i,
  input  wire                        wr_i,
  input  wire                        rd_i,
  input  wire [1:0]                  reg_ofs_i,
  output demod_pkg::reg_word_t       misc_dout_o,
  output logic                       soft_rst_req_o
);

  logic                 clock_wr;     // write to the clock register
  logic                 reset_rd;     // read of the reset register
  logic                 start_flag;
  logic                 start_s0;
  logic                 start_s1;
  logic                 restart;
  demod_pkg::reg_word_t clock_count;
  logic                 sel_d1;
  logic                 sel_d2;
  logic                 snap;
  demod_pkg::reg_word_t clock_hold;

  assign clock_wr = wr_i & misc_sel_i & (reg_ofs_i == `MISC_CLOCK_OFS);
  assign reset_rd = rd_i & misc_sel_i & (reg_ofs_i == `MISC_RESET_OFS);

  // ********************
  // clock counter
  // ********************

  // start flag sets on the write, cleared by the restart it causes
  always_ff @(posedge ck933 or posedge clockCounterEn) begin
    if (clockCounterEn) begin
      start_flag <= 1'b0;
    end else if (restart) begin
      start_flag <= 1'b0;
    end else if (clock_wr) begin
      start_flag <= 1'b1;
    end
  end

  assign restart = start_s0 & ~start_s1;   // rising edge of the synced flag

  always_ff @(posedge ck933 or posedge clockCounterEn) begin
    if (clockCounterEn) begin
      start_s0    <= 1'b0;
      start_s1    <= 1'b0;
      clock_count <= '0;
    end else begin
      start_s0 <= start_flag;
      start_s1 <= start_s0;
      if (restart) begin
        clock_count <= '0;
      end else begin
        clock_count <= clock_count + 1'b1;   // free running, wraps
      end
    end
  end

  // ********************
  // snapshot on select
  // ********************

  // each new access to the space freezes the count for readback
  assign snap = sel_d1 & ~sel_d2;

  always_ff @(posedge ck933 or posedge clockCounterEn) begin
    if (clockCounterEn) begin
      sel_d1     <= 1'b0;
      sel_d2     <= 1'b0;
      clock_hold <= '0;
    end else begin
      sel_d1 <= misc_sel_i;
      sel_d2 <= sel_d1;
      if (snap) begin
        clock_hold <= clock_count;
      end
    end
  end

  always_comb begin
    case (reg_ofs_i)
      `MISC_VERSION_OFS: misc_dout_o = {`VERSION_NUMBER, 16'h0000};
      `MISC_CLOCK_OFS:   misc_dout_o = clock_hold;
      default:           misc_dout_o = '0;   // reset reg reads zero
    endcase
  end

  // one clock request per read of the reset register
  always_ff @(posedge ck933 or posedge clockCounterEn) begin
    if (clockCounterEn) begin
      soft_rst_req_o <= 1'b0;
    end else begin
      soft_rst_req_o <= reset_rd;
    end
  end

endmodule

`default_nettype wire

/* logic/soft_reset_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "demod_defs.svh"

module soft_reset_gen (
  input  wire  ck933,
  input  wire  clockCounterEn,
  input  wire  soft_rst_req_i,
  output logic soft_rst_o
);

  localparam int CNT_W = $clog2(`SOFT_RESET_CYCLES);

  logic             req_q;   // request, one clock later
  logic [CNT_W-1:0] rst_cnt; // cycles left after the first one

  // ********************
  // pulse stretcher
  // ********************

  // a new request reloads the count, so the pulse restarts
  always_ff @(posedge ck933 or posedge clockCounterEn) begin
    if (clockCounterEn) begin
      req_q      <= 1'b0;
      rst_cnt    <= '0;
      soft_rst_o <= 1'b0;
    end else begin
      req_q <= soft_rst_req_i;
      if (req_q) begin
        rst_cnt    <= CNT_W'(`SOFT_RESET_CYCLES - 1);
        soft_rst_o <= 1'b1;
      end else if (rst_cnt != '0) begin
        rst_cnt    <= rst_cnt - 1'b1;
        soft_rst_o <= 1'b1;
      end else begin
        soft_rst_o <= 1'b0;   // expired
      end
    end
  end

endmodule

`default_nettype wire

/* logic/if_dac_path.sv */
`timescale 1ns/1ps
`default_nettype none

`include "demod_defs.svh"

module if_dac_path (
  input  wire                         ck933,
  input  wire                         clockCounterEn,
  input  wire                         soft_rst_i,
  input  wire demod_pkg::adc_sample_t adc_d_i,
  output demod_pkg::dac_code_t        dac0_d_o
);

  localparam int IF_W  = $bits(demod_pkg::if_sample_t);
  localparam int DAC_W = $bits(demod_pkg::dac_code_t);

  localparam demod_pkg::dac_code_t DAC_MIDSCALE = 14'h2000;   // zero sample

  logic                   sample_clr;   // either reset, flops read zero at once
  demod_pkg::adc_sample_t adc_q;
  demod_pkg::if_sample_t  if_sample;

  assign sample_clr = clockCounterEn | soft_rst_i;

  // ********************
  // adc reclock
  // ********************

  always_ff @(posedge ck933 or posedge sample_clr) begin
    if (sample_clr) begin
      adc_q <= '0;
    end else begin
      adc_q <= adc_d_i;
    end
  end

  assign if_sample = {adc_q, {`IF_PAD_BITS{1'b0}}};   // low bits padded

  // top bits with msb flipped, two's complement to offset binary
  always_ff @(posedge ck933 or posedge sample_clr) begin
    if (sample_clr) begin
      dac0_d_o <= DAC_MIDSCALE;
    end else begin
      dac0_d_o <= {~if_sample[IF_W-1], if_sample[IF_W-2 -: DAC_W-1]};
    end
  end

endmodule

`default_nettype wire

/* logic/demod_top.sv */
`timescale 1ns/1ps
`default_nettype none

module demod_top (
  input  wire                        ck933,
  input  wire                        clockCounterEn,   // async reset, active high
  input  wire                        cs_n_i,
  input  wire                        rd_n_i,
  input  wire                        we_n_i,
  input  wire demod_pkg::bus_addr_t  addr_i,
  input  wire demod_pkg::bus_data_t  data_i,           // no writable data field yet
  input  wire demod_pkg::adc_sample_t adc_d_i,
  output wire demod_pkg::bus_data_t  data_o,
  output wire                        data_oe_o,
  output wire                        dac_rst_o,
  output wire demod_pkg::dac_code_t  dac0_d_o
);

  logic                 misc_sel;       // cs low and address in misc space
  logic                 wr;
  logic                 rd;             // first cycle of a read only
  demod_pkg::reg_word_t misc_dout;
  logic                 soft_rst_req;   // one clock wide
  logic                 soft_rst;

  // ********************
  // processor bus
  // ********************

  cpu_bus_decode u_bus (
    .ck933          (ck933),
    .clockCounterEn (clockCounterEn),
    .cs_n_i         (cs_n_i),
    .rd_n_i         (rd_n_i),
    .we_n_i         (we_n_i),
    .addr_i         (addr_i),
    .misc_dout_i    (misc_dout),
    .misc_sel_o     (misc_sel),
    .wr_o           (wr),
    .rd_o           (rd),
    .data_o         (data_o),
    .data_oe_o      (data_oe_o)
  );

  // ********************
  // misc space and reset
  // ********************

  // a clock register write restarts the counter whatever the value on data_i
  misc_regs u_misc (
    .ck933          (ck933),
    .clockCounterEn (clockCounterEn),
    .misc_sel_i     (misc_sel),
    .wr_i           (wr),
    .rd_i           (rd),
    .reg_ofs_i      (addr_i[3:2]),
    .misc_dout_o    (misc_dout),
    .soft_rst_req_o (soft_rst_req)
  );

  soft_reset_gen u_soft_rst (
    .ck933          (ck933),
    .clockCounterEn (clockCounterEn),
    .soft_rst_req_i (soft_rst_req),
    .soft_rst_o     (soft_rst)
  );

  assign dac_rst_o = soft_rst;   // same pulse goes out to the dac

  // ********************
  // if sample path
  // ********************

  // interpolators bypassed, dac0 runs on every clock
  if_dac_path u_if_dac (
    .ck933          (ck933),
    .clockCounterEn (clockCounterEn),
    .soft_rst_i     (soft_rst),
    .adc_d_i        (adc_d_i),
    .dac0_d_o       (dac0_d_o)
  );

endmodule

`default_nettype wire

/* sim/tb_demod_checks.svh */
// ********************
// typed compare tasks
// ********************

task automatic check_data(input string what, input demod_pkg::bus_data_t got,
                          input demod_pkg::bus_data_t exp, inout int errs);
  if (got !== exp) begin
    errs++;
    $display("MISMATCH at %0t: %s read %h, expected %h", $time, what, got, exp);
  end
endtask

task automatic check_dac(input string what, input demod_pkg::dac_code_t got,
                         input demod_pkg::dac_code_t exp, inout int errs);
  if (got !== exp) begin
    errs++;
    $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
  end
endtask

task automatic check_flag(input string what, input logic got, input logic exp,
                          inout int errs);
  if (got !== exp) begin
    errs++;
    $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
  end
endtask

// ********************
// bus cycles
// ********************

// n_edge is the rising edge that samples the write
task automatic bus_write(input demod_pkg::bus_addr_t a, input demod_pkg::bus_data_t d,
                         output int n_edge);
  @(posedge ck933);
  cs_n    <= 1'b0;
  we_n    <= 1'b0;
  addr    <= a;
  data_in <= d;
  @(negedge ck933);
  n_edge = edge_cnt + 1;
  @(posedge ck933);
  cs_n <= 1'b1;
  we_n <= 1'b1;
endtask

// s_edge is the first edge that samples the access, data taken after s_edge+1
task automatic bus_read(input demod_pkg::bus_addr_t a, output demod_pkg::bus_data_t d,
                        output int s_edge);
  @(posedge ck933);
  cs_n <= 1'b0;
  rd_n <= 1'b0;
  addr <= a;
  @(negedge ck933);
  s_edge = edge_cnt + 1;
  check_flag("data_oe_o during read", data_oe, 1'b1, seq_errs);
  repeat (2) @(posedge ck933);
  @(negedge ck933);
  d = data_out;   // hold register settled by now
  @(posedge ck933);
  cs_n <= 1'b1;
  rd_n <= 1'b1;
  @(negedge ck933);
  check_flag("data_oe_o after read", data_oe, 1'b0, seq_errs);
endtask

/* sim/tb_demod_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_demod_top;

  parameter int SEED = 54907;

  localparam int CLK_PERIOD    = 20;
  localparam int N_SAMPLES     = 200;
  localparam int TEST_CYCLES   = N_SAMPLES + 80;   // all five tests together
  localparam int MARGIN_CYCLES = 100;
  localparam time WATCHDOG_NS  = (TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

  localparam demod_pkg::bus_data_t VERSION_EXP  = 16'h005d;
  localparam demod_pkg::dac_code_t MIDSCALE     = 14'h2000;
  localparam demod_pkg::bus_addr_t ADDR_RESET   = 11'h3f0;
  localparam demod_pkg::bus_addr_t ADDR_VER_LO  = 11'h3f4;
  localparam demod_pkg::bus_addr_t ADDR_VER_HI  = 11'h3f6;   // bit 1 picks upper half
  localparam demod_pkg::bus_addr_t ADDR_CLOCK   = 11'h3f8;
  localparam demod_pkg::bus_addr_t ADDR_OUTSIDE = 11'h126;   // low bits hit version upper

  logic                   ck933;
  logic                   clockCounterEn;
  logic                   cs_n;
  logic                   rd_n;
  logic                   we_n;
  demod_pkg::bus_addr_t   addr;
  demod_pkg::bus_data_t   data_in;
  demod_pkg::adc_sample_t adc_d;
  demod_pkg::bus_data_t   data_out;
  logic                   data_oe;
  logic                   dac_rst;
  demod_pkg::dac_code_t   dac0_d;

  int edge_cnt = 0;
  int seq_errs = 0;     // bus and sequence checks
  int mon_errs = 0;     // comparing process
  int other_cnt = 0;
  int rst_edge = -100;  // edge R of the reset read
  int rst_len = 0;
  logic stream_chk = 1'b0;
  demod_pkg::adc_sample_t adc_hist [2] = '{14'h0, 14'h0};

  `include "tb_demod_checks.svh"

  demod_top u_dut (
    .ck933          (ck933),
    .clockCounterEn (clockCounterEn),
    .cs_n_i         (cs_n),
    .rd_n_i         (rd_n),
    .we_n_i         (we_n),
    .addr_i         (addr),
    .data_i         (data_in),
    .adc_d_i        (adc_d),
    .data_o         (data_out),
    .data_oe_o      (data_oe),
    .dac_rst_o      (dac_rst),
    .dac0_d_o       (dac0_d)
  );

  initial begin
    ck933 = 1'b0;
    forever #(CLK_PERIOD / 2) ck933 = ~ck933;
  end

  always @(posedge ck933) edge_cnt <= edge_cnt + 1;

  // ********************
  // reference model
  // ********************

  // offset binary is the signed sample plus midscale, padding keeps the word
  function automatic demod_pkg::dac_code_t ref_dac(input demod_pkg::adc_sample_t s);
    return s + MIDSCALE;
  endfunction

  function automatic demod_pkg::bus_data_t ref_count(input int s_edge, input int n_edge);
    return demod_pkg::bus_data_t'(s_edge - n_edge - 2);
  endfunction

  function automatic logic ref_soft_rst(input int k, input int r);
    return (r >= 0) && (k >= r + 2) && (k <= r + 7);   // six cycles
  endfunction

  // dac value after edge k comes from the adc word seen two negedges back
  always @(negedge ck933) begin
    if (!clockCounterEn) begin
      check_flag("dac_rst_o", dac_rst, ref_soft_rst(edge_cnt, rst_edge), mon_errs);
      if (dac_rst) begin
        rst_len++;
        check_dac("dac0_d_o in soft reset", dac0_d, MIDSCALE, mon_errs);
      end else if (stream_chk) begin
        check_dac("dac0_d_o", dac0_d, ref_dac(adc_hist[1]), mon_errs);
      end
    end
    adc_hist[1] = adc_hist[0];
    adc_hist[0] = adc_d;
  end

  // ********************
  // stimulus
  // ********************

  initial begin
    int n_edge;
    int s1;
    int s2;
    demod_pkg::bus_data_t rdata;
    demod_pkg::bus_data_t c1;
    demod_pkg::bus_data_t c2;
    void'($urandom(SEED));
    clockCounterEn = 1'b1;
    cs_n    = 1'b1;
    rd_n    = 1'b1;
    we_n    = 1'b1;
    addr    = '0;
    data_in = '0;
    adc_d   = '0;
    repeat (3) @(posedge ck933);
    clockCounterEn <= 1'b0;

    // idle state after reset
    @(negedge ck933);
    check_flag("dac_rst_o after reset", dac_rst, 1'b0, seq_errs);
    check_dac("dac0_d_o after reset", dac0_d, MIDSCALE, seq_errs);
    check_flag("data_oe_o idle", data_oe, 1'b0, seq_errs);

    bus_read(ADDR_VER_HI, rdata, s1);
    check_data("version upper half", rdata, VERSION_EXP, seq_errs);
    bus_read(ADDR_VER_LO, rdata, s1);
    check_data("version lower half", rdata, 16'h0000, seq_errs);
    bus_read(ADDR_OUTSIDE, rdata, s1);
    check_data("unmapped read", rdata, 16'h0000, seq_errs);

    // random adc stream through the sample path
    @(posedge ck933);
    stream_chk <= 1'b1;
    repeat (N_SAMPLES) begin
      @(posedge ck933);
      adc_d <= demod_pkg::adc_sample_t'($urandom);
    end
    repeat (3) @(posedge ck933);
    stream_chk <= 1'b0;

    // clock counter restart and two snapshots
    bus_write(ADDR_CLOCK, 16'h0000, n_edge);
    repeat (4) @(posedge ck933);
    bus_read(ADDR_CLOCK, c1, s1);
    check_data("clock snapshot 1", c1, ref_count(s1, n_edge), seq_errs);
    repeat (5 + $urandom % 20) @(posedge ck933);
    bus_read(ADDR_CLOCK, c2, s2);
    check_data("clock snapshot 2", c2, ref_count(s2, n_edge), seq_errs);
    check_data("snapshot difference", c2 - c1, demod_pkg::bus_data_t'(s2 - s1), seq_errs);

    // soft reset, the read will be sampled two edges from here
    @(negedge ck933);
    rst_edge = edge_cnt + 2;
    bus_read(ADDR_RESET, rdata, s1);
    repeat (10) begin
      @(posedge ck933);
      adc_d <= demod_pkg::adc_sample_t'($urandom);
    end
    @(negedge ck933);
    if (rst_len != 6) begin
      other_cnt++;
      $display("soft reset pulse lasted %0d cycles instead of 6", rst_len);
    end

    $display("errors: %0d mismatches, %0d other failures", seq_errs + mon_errs, other_cnt);
    if (seq_errs + mon_errs + other_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("timeout: tests did not finish within %0d cycles", TEST_CYCLES + MARGIN_CYCLES);
    $display("errors: %0d mismatches, %0d other failures", seq_errs + mon_errs, other_cnt + 1);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* demod_top.f */
+incdir+include
+incdir+sim
logic/demod_pkg.sv
logic/cpu_bus_decode.sv
logic/misc_regs.sv
logic/soft_reset_gen.sv
logic/if_dac_path.sv
logic/demod_top.sv
sim/tb_demod_top.sv

/* Makefile */
# Verilator build and run for the demodulator control core

VERILATOR ?= verilator
TOP       ?= tb_demod_top
FILELIST  ?= demod_top.f
BUILD_DIR ?= build
LOG       ?= sim.log
SEED      ?= 54907

SRCS := $(wildcard logic/*.sv sim/*.sv sim/*.svh include/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TOP) \
	  -GSEED=$(SEED) -Mdir $(BUILD_DIR)

run: $(BIN)
	$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG) || ! grep -q "STATUS: PASS" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
